//--- hdl/cgra_pkg.sv
package cgra_pkg;

    localparam int DATA_W = 32;
    localparam int ADDR_W = 10;
    localparam int IMM_W  = 16;
    localparam int MAX_PE = 8;

    // Index into the PE row as carried in cmd.addr
    localparam int PE_IDX_W = $clog2(MAX_PE);

    typedef enum logic [2:0] {
        CMD_CFG_PE  = 3'd0,
        CMD_CFG_LSU = 3'd1,
        CMD_MEM_WR  = 3'd2,
        CMD_MEM_RD  = 3'd3,
        CMD_RUN     = 3'd4
    } host_op_e;

    typedef enum logic [2:0] {
        OP_PASS = 3'd0,
        OP_ADD  = 3'd1,
        OP_SUB  = 3'd2,
        OP_MUL  = 3'd3,
        OP_AND  = 3'd4,
        OP_XOR  = 3'd5,
        OP_SHL  = 3'd6
    } pe_op_e;

    typedef struct packed {
        host_op_e            op;
        logic [ADDR_W-1:0]   addr;
        logic [DATA_W-1:0]   data;
    } host_cmd_t;

    typedef struct packed {
        pe_op_e              op;
        logic [IMM_W-1:0]    imm;   // Sign-extended in the PE
    } pe_cfg_t;

    localparam int PE_CFG_W = $bits(pe_cfg_t);

    typedef struct packed {
        logic [ADDR_W-1:0]   src_base;
        logic [ADDR_W-1:0]   dst_base;
        logic [ADDR_W-1:0]   count;
    } lsu_cfg_t;

    typedef struct packed {
        logic [DATA_W-1:0]   data;
    } host_rsp_t;

    typedef struct packed {
        logic                valid;
        logic [DATA_W-1:0]   data;
    } stream_t;

endpackage

//--- hdl/cgra_spm.sv
`timescale 1ns/1ps

module cgra_spm import cgra_pkg::*; #(
    parameter int SPM_DEPTH = 256
) (
    input  logic                clk,
    input  logic                re,
    input  logic [ADDR_W-1:0]   raddr,
    output logic [DATA_W-1:0]   rdata,
    input  logic                we,
    input  logic [ADDR_W-1:0]   waddr,
    input  logic [DATA_W-1:0]   wdata
);

    localparam int IDX_W = $clog2(SPM_DEPTH);

    logic [DATA_W-1:0] mem [SPM_DEPTH];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr[IDX_W-1:0]] <= wdata;
        end
    end

    // Old word on a shared address and rdata held when idle
    always_ff @(posedge clk) begin
        if (re) begin
            rdata <= mem[raddr[IDX_W-1:0]];
        end
    end

    a_raddr_range: assert property (@(posedge clk)
        re |-> raddr < ADDR_W'(SPM_DEPTH));

    a_waddr_range: assert property (@(posedge clk)
        we |-> waddr < ADDR_W'(SPM_DEPTH));

endmodule

//--- hdl/cgra_host_if.sv
`timescale 1ns/1ps

module cgra_host_if import cgra_pkg::*; #(
    parameter int NUM_PE = 4
) (
    input  logic                clk,
    input  logic                arst_n,
    input  host_cmd_t           cmd,
    input  logic                cmd_valid,
    output logic                cmd_ready,
    output host_rsp_t           rsp,
    output logic                rsp_valid,
    input  logic                rsp_ready,
    output pe_cfg_t             pe_cfg [NUM_PE],
    output lsu_cfg_t            lsu_cfg,
    output logic                start,
    input  logic                done,
    output logic                host_we,
    output logic [ADDR_W-1:0]   host_waddr,
    output logic [DATA_W-1:0]   host_wdata,
    output logic                host_re,
    output logic [ADDR_W-1:0]   host_raddr,
    input  logic [DATA_W-1:0]   spm_rdata
);

    typedef enum logic [1:0] {
        IDLE,
        READ_WAIT,
        RSP_HOLD,
        RUNNING
    } state_e;

    state_e                state, state_nxt;
    logic                  accept;
    logic [PE_IDX_W-1:0]   pe_idx;
    logic                  pe_hit;
    logic [DATA_W-1:0]     rsp_data;
    logic                  start_q;

    assign cmd_ready = (state == IDLE);
    assign accept    = cmd_valid && cmd_ready;
    assign pe_idx    = cmd.addr[PE_IDX_W-1:0];
    assign pe_hit    = (cmd.addr < ADDR_W'(NUM_PE));   // Out of range PE writes dropped

    // SPM access straight from the accepted command
    assign host_we    = accept && (cmd.op == CMD_MEM_WR);
    assign host_waddr = cmd.addr;
    assign host_wdata = cmd.data;
    assign host_re    = accept && (cmd.op == CMD_MEM_RD);
    assign host_raddr = cmd.addr;

    assign rsp.data  = rsp_data;
    assign rsp_valid = (state == RSP_HOLD);
    assign start     = start_q;

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (accept && cmd.op == CMD_MEM_RD) state_nxt = READ_WAIT;
                if (accept && cmd.op == CMD_RUN)    state_nxt = RUNNING;
            end
            READ_WAIT: state_nxt = RSP_HOLD;
            RSP_HOLD:  if (rsp_ready) state_nxt = IDLE;
            RUNNING:   if (done) state_nxt = IDLE;
            default:   state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state   <= IDLE;
            start_q <= 1'b0;
            lsu_cfg <= '0;
            for (int k = 0; k < NUM_PE; k++) begin
                pe_cfg[k] <= '{op: OP_PASS, imm: '0};
            end
        end else begin
            state   <= state_nxt;
            start_q <= accept && (cmd.op == CMD_RUN);
            for (int k = 0; k < NUM_PE; k++) begin
                if (accept && cmd.op == CMD_CFG_PE && pe_hit && pe_idx == PE_IDX_W'(k)) begin
                    pe_cfg[k] <= pe_cfg_t'(cmd.data[PE_CFG_W-1:0]);
                end
            end
            if (accept && cmd.op == CMD_CFG_LSU) begin
                case (cmd.addr)
                    ADDR_W'(0): lsu_cfg.src_base <= cmd.data[ADDR_W-1:0];
                    ADDR_W'(1): lsu_cfg.dst_base <= cmd.data[ADDR_W-1:0];
                    ADDR_W'(2): lsu_cfg.count    <= cmd.data[ADDR_W-1:0];
                    default: ;
                endcase
            end
        end
    end

    // Capture SPM data one cycle after the read was issued
    always_ff @(posedge clk) begin
        if (state == READ_WAIT) rsp_data <= spm_rdata;
    end

    a_rsp_stable: assert property (@(posedge clk) disable iff (!arst_n)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp));

endmodule

//--- hdl/cgra_load_lsu.sv
`timescale 1ns/1ps

module cgra_load_lsu import cgra_pkg::*; (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                start,
    input  lsu_cfg_t            lsu_cfg,
    output logic                re,
    output logic [ADDR_W-1:0]   raddr,
    input  logic [DATA_W-1:0]   spm_rdata,
    output stream_t             out
);

    logic                active;
    logic [ADDR_W-1:0]   addr_q;
    logic [ADDR_W-1:0]   remain_q;
    logic                valid_q;   // Read issued last cycle

    assign re    = active;
    assign raddr = addr_q;

    // SPM data arrives one cycle after the read
    assign out.valid = valid_q;
    assign out.data  = spm_rdata;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            active   <= 1'b0;
            addr_q   <= '0;
            remain_q <= '0;
            valid_q  <= 1'b0;
        end else begin
            valid_q <= active;
            if (start) begin
                active   <= (lsu_cfg.count != '0);
                addr_q   <= lsu_cfg.src_base;
                remain_q <= lsu_cfg.count;
            end else if (active) begin
                addr_q   <= addr_q + 1'b1;
                remain_q <= remain_q - 1'b1;
                if (remain_q == ADDR_W'(1)) begin
                    active <= 1'b0;   // Last word issued
                end
            end
        end
    end

    a_no_restart: assert property (@(posedge clk) disable iff (!arst_n)
        active |-> !start);

endmodule

//--- hdl/cgra_pe.sv
`timescale 1ns/1ps

module cgra_pe import cgra_pkg::*; (
    input  logic      clk,
    input  logic      arst_n,
    input  pe_cfg_t   cfg,
    input  stream_t   in,
    output stream_t   out
);

    logic [DATA_W-1:0]   imm_ext;
    logic [DATA_W-1:0]   result;
    logic                valid_q;
    logic [DATA_W-1:0]   data_q;

    assign imm_ext = {{(DATA_W-IMM_W){cfg.imm[IMM_W-1]}}, cfg.imm};

    always_comb begin
        case (cfg.op)
            OP_PASS: result = in.data;
            OP_ADD:  result = in.data + imm_ext;
            OP_SUB:  result = in.data - imm_ext;
            OP_MUL:  result = in.data * imm_ext;   // Low word of product
            OP_AND:  result = in.data & imm_ext;
            OP_XOR:  result = in.data ^ imm_ext;
            OP_SHL:  result = in.data << cfg.imm[4:0];
            default: result = in.data;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= in.valid;
        end
    end

    // Payload only moves with a valid word
    always_ff @(posedge clk) begin
        if (in.valid) begin
            data_q <= result;
        end
    end

    assign out.valid = valid_q;
    assign out.data  = data_q;

endmodule

//--- hdl/cgra_store_lsu.sv
`timescale 1ns/1ps

module cgra_store_lsu import cgra_pkg::*; (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                start,
    input  lsu_cfg_t            lsu_cfg,
    input  stream_t             in,
    output logic                we,
    output logic [ADDR_W-1:0]   waddr,
    output logic [DATA_W-1:0]   wdata,
    output logic                done
);

    logic [ADDR_W-1:0]   idx_q;
    logic                last_wr;
    logic                zero_q;   // Empty run in flight
    logic                done_q;

    assign we      = in.valid;
    assign waddr   = lsu_cfg.dst_base + idx_q;
    assign wdata   = in.data;
    assign last_wr = in.valid && (idx_q == lsu_cfg.count - 1'b1);
    assign done    = done_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            idx_q  <= '0;
            zero_q <= 1'b0;
            done_q <= 1'b0;
        end else begin
            if (start) begin
                idx_q <= '0;
            end else if (in.valid) begin
                idx_q <= idx_q + 1'b1;
            end
            // Count zero still reports done two cycles after start
            zero_q <= start && (lsu_cfg.count == '0);
            done_q <= last_wr || zero_q;
        end
    end

endmodule

//--- hdl/cgra_top.sv
`timescale 1ns/1ps

module cgra_top import cgra_pkg::*; #(
    parameter int NUM_PE    = 4,
    parameter int SPM_DEPTH = 256
) (
    input  logic        clk,
    input  logic        arst_n,
    input  host_cmd_t   cmd,
    input  logic        cmd_valid,
    output logic        cmd_ready,
    output host_rsp_t   rsp,
    output logic        rsp_valid,
    input  logic        rsp_ready,
    output logic        done
);

    if (NUM_PE > MAX_PE) begin : g_num_pe_check
        $error("NUM_PE exceeds MAX_PE");
    end

    pe_cfg_t             pe_cfg [NUM_PE];
    lsu_cfg_t            lsu_cfg;
    logic                start;

    logic                host_we, host_re;
    logic [ADDR_W-1:0]   host_waddr, host_raddr;
    logic [DATA_W-1:0]   host_wdata;

    logic                lsu_we, lsu_re;
    logic [ADDR_W-1:0]   lsu_waddr, lsu_raddr;
    logic [DATA_W-1:0]   lsu_wdata;

    logic                spm_we, spm_re;
    logic [ADDR_W-1:0]   spm_waddr, spm_raddr;
    logic [DATA_W-1:0]   spm_wdata, spm_rdata;

    stream_t             pe_stream [NUM_PE+1];

    // LSUs own the SPM whenever the host is not accepting commands
    assign spm_re    = cmd_ready ? host_re    : lsu_re;
    assign spm_raddr = cmd_ready ? host_raddr : lsu_raddr;
    assign spm_we    = cmd_ready ? host_we    : lsu_we;
    assign spm_waddr = cmd_ready ? host_waddr : lsu_waddr;
    assign spm_wdata = cmd_ready ? host_wdata : lsu_wdata;

    cgra_host_if #(.NUM_PE(NUM_PE)) u_host_if (
        .clk        (clk),
        .arst_n     (arst_n),
        .cmd        (cmd),
        .cmd_valid  (cmd_valid),
        .cmd_ready  (cmd_ready),
        .rsp        (rsp),
        .rsp_valid  (rsp_valid),
        .rsp_ready  (rsp_ready),
        .pe_cfg     (pe_cfg),
        .lsu_cfg    (lsu_cfg),
        .start      (start),
        .done       (done),
        .host_we    (host_we),
        .host_waddr (host_waddr),
        .host_wdata (host_wdata),
        .host_re    (host_re),
        .host_raddr (host_raddr),
        .spm_rdata  (spm_rdata)
    );

    cgra_spm #(.SPM_DEPTH(SPM_DEPTH)) u_spm (
        .clk   (clk),
        .re    (spm_re),
        .raddr (spm_raddr),
        .rdata (spm_rdata),
        .we    (spm_we),
        .waddr (spm_waddr),
        .wdata (spm_wdata)
    );

    cgra_load_lsu u_load_lsu (
        .clk       (clk),
        .arst_n    (arst_n),
        .start     (start),
        .lsu_cfg   (lsu_cfg),
        .re        (lsu_re),
        .raddr     (lsu_raddr),
        .spm_rdata (spm_rdata),
        .out       (pe_stream[0])
    );

    for (genvar k = 0; k < NUM_PE; k++) begin : g_pe
        cgra_pe u_pe (
            .clk    (clk),
            .arst_n (arst_n),
            .cfg    (pe_cfg[k]),
            .in     (pe_stream[k]),
            .out    (pe_stream[k+1])
        );
    end

    cgra_store_lsu u_store_lsu (
        .clk     (clk),
        .arst_n  (arst_n),
        .start   (start),
        .lsu_cfg (lsu_cfg),
        .in      (pe_stream[NUM_PE]),
        .we      (lsu_we),
        .waddr   (lsu_waddr),
        .wdata   (lsu_wdata),
        .done    (done)
    );

endmodule

//--- include/cgra_tb_table.svh
`ifndef CGRA_TB_TABLE_SVH
`define CGRA_TB_TABLE_SVH

// PE row setup plus the block streamed through it
typedef struct packed {
    pe_cfg_t [0:NUM_PE-1]   pe;
    logic [ADDR_W-1:0]      src_base;
    logic [ADDR_W-1:0]      dst_base;
    logic [ADDR_W-1:0]      count;
} tcase_t;

localparam int NUM_CASES = 6;

localparam tcase_t CASES [NUM_CASES] = '{
    '{pe: '{'{OP_ADD, 16'h0005}, '{OP_SUB, 16'hFFFD}, '{OP_MUL, 16'h0007}, '{OP_XOR, 16'h8001}},
      src_base: 10'd16, dst_base: 10'd64, count: 10'd8},
    // Negative mask and add of minus one
    '{pe: '{'{OP_AND, 16'hF0F0}, '{OP_SHL, 16'h0004}, '{OP_PASS, 16'h1234}, '{OP_ADD, 16'hFFFF}},
      src_base: 10'd0, dst_base: 10'd128, count: 10'd16},
    '{pe: '{'{OP_MUL, 16'hFFFE}, '{OP_SHL, 16'h001F}, '{OP_SUB, 16'h7FFF}, '{OP_PASS, 16'h0000}},
      src_base: 10'd200, dst_base: 10'd32, count: 10'd5},
    // Empty run
    '{pe: '{'{OP_PASS, 16'h0000}, '{OP_PASS, 16'h0000}, '{OP_PASS, 16'h0000}, '{OP_PASS, 16'h0000}},
      src_base: 10'd10, dst_base: 10'd100, count: 10'd0},
    '{pe: '{'{OP_XOR, 16'h1234}, '{OP_AND, 16'h00FF}, '{OP_SHL, 16'h0023}, '{OP_MUL, 16'h0003}},
      src_base: 10'd40, dst_base: 10'd160, count: 10'd12},
    // Destination at the bottom of the SPM
    '{pe: '{'{OP_SUB, 16'h8000}, '{OP_ADD, 16'h7FFF}, '{OP_SHL, 16'h0001}, '{OP_AND, 16'hFFFF}},
      src_base: 10'd250, dst_base: 10'd0, count: 10'd4}
};

`endif

//--- dv/cgra_tb.sv
`timescale 1ns/1ps

module cgra_tb import cgra_pkg::*; ();

    localparam int NUM_PE    = 4;
    localparam int SPM_DEPTH = 256;
    localparam int WAIT_MAX  = 500;   // Cycles for any single handshake

    `include "cgra_tb_table.svh"

    logic        clk;
    logic        arst_n;
    host_cmd_t   cmd;
    logic        cmd_valid;
    logic        cmd_ready;
    host_rsp_t   rsp;
    logic        rsp_valid;
    logic        rsp_ready;
    logic        done;

    logic [DATA_W-1:0] shadow [SPM_DEPTH];   // Expected SPM contents

    int done_pulses;   // Cycles seen with done high
    int runs;

    cgra_top #(.NUM_PE(NUM_PE), .SPM_DEPTH(SPM_DEPTH)) dut0 (
        .clk       (clk),
        .arst_n    (arst_n),
        .cmd       (cmd),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready),
        .rsp       (rsp),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .done      (done)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        done_pulses = 0;
        forever begin
            @(negedge clk);
            if (done) done_pulses++;
        end
    end

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("Done: errors found");
        $fatal(1);
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            abort_run($sformatf("ERR %s expected 0x%h actual 0x%h", name, exp, act));
        end
    endtask

    task automatic check_rsp(input string name, input host_rsp_t exp, input host_rsp_t act);
        if (act !== exp) begin
            abort_run($sformatf("ERR %s expected 0x%h actual 0x%h", name, exp, act));
        end
    endtask

    function automatic logic [DATA_W-1:0] fill_word(input int a);
        return (DATA_W'(a) * 32'h9E37_79B1) ^ 32'hC3A5_0000;
    endfunction

    // One PE stage as the opcode table defines it
    function automatic logic [DATA_W-1:0] apply_pe(input pe_cfg_t c, input logic [DATA_W-1:0] d);
        logic [DATA_W-1:0] imm;
        imm = DATA_W'($signed(c.imm));
        case (c.op)
            OP_ADD:  return d + imm;
            OP_SUB:  return d - imm;
            OP_MUL:  return d * imm;
            OP_AND:  return d & imm;
            OP_XOR:  return d ^ imm;
            OP_SHL:  return d << c.imm[4:0];
            default: return d;
        endcase
    endfunction

    function automatic int watch_cycles();
        int words;
        words = SPM_DEPTH;
        for (int i = 0; i < NUM_CASES; i++) begin
            words += 2 * int'(CASES[i].count);   // Source fill and result
        end
        return NUM_CASES * 200 + 50 * words;
    endfunction

    // Entered 1 ns after a rising edge and left 1 ns after the transfer edge
    task automatic send_cmd(input host_op_e op, input logic [ADDR_W-1:0] addr,
                            input logic [DATA_W-1:0] data);
        int n;
        n = 0;
        cmd       = '{op: op, addr: addr, data: data};
        cmd_valid = 1'b1;
        @(negedge clk);
        while (!cmd_ready) begin
            n++;
            if (n > WAIT_MAX) abort_run("timeout waiting for cmd_ready");
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        cmd_valid = 1'b0;
    endtask

    task automatic mem_write(input int a, input logic [DATA_W-1:0] d);
        shadow[a] = d;
        send_cmd(CMD_MEM_WR, ADDR_W'(a), d);
    endtask

    task automatic mem_read_check(input int a);
        host_rsp_t held;
        int        stall;
        int        n;
        n = 0;
        send_cmd(CMD_MEM_RD, ADDR_W'(a), '0);
        do begin
            @(negedge clk);
            check_bit("cmd_ready", 1'b0, cmd_ready);
            n++;
            if (n > WAIT_MAX) abort_run("timeout waiting for rsp_valid");
        end while (!rsp_valid);
        held  = rsp;
        stall = $urandom_range(0, 4);
        repeat (stall) begin   // Back-pressure
            @(negedge clk);
            check_bit("rsp_valid", 1'b1, rsp_valid);
            check_bit("cmd_ready", 1'b0, cmd_ready);
            check_rsp("rsp", held, rsp);
        end
        @(posedge clk);
        #1 rsp_ready = 1'b1;
        @(negedge clk);
        check_bit("rsp_valid", 1'b1, rsp_valid);
        check_rsp("rsp", held, rsp);
        @(posedge clk);
        #1 rsp_ready = 1'b0;
        @(negedge clk);
        check_bit("rsp_valid", 1'b0, rsp_valid);
        check_bit("cmd_ready", 1'b1, cmd_ready);
        check_rsp($sformatf("rsp.data @0x%h", a), host_rsp_t'{data: shadow[a]}, held);
        @(posedge clk);
        #1;
    endtask

    task automatic run_block();
        int n;
        n = 0;
        send_cmd(CMD_RUN, '0, '0);
        do begin
            @(negedge clk);
            check_bit("cmd_ready", 1'b0, cmd_ready);
            n++;
            if (n > WAIT_MAX) abort_run("timeout waiting for done");
        end while (!done);
        @(negedge clk);
        check_bit("done", 1'b0, done);   // Single-cycle pulse
        check_bit("cmd_ready", 1'b1, cmd_ready);
        @(posedge clk);
        #1;
        runs++;
        if (done_pulses != runs) abort_run("done did not pulse exactly once for the run");
    endtask

    task automatic run_case(input tcase_t tc);
        logic [DATA_W-1:0] res [$];
        logic [DATA_W-1:0] d;
        int src;
        int dst;
        int cnt;
        src = int'(tc.src_base);
        dst = int'(tc.dst_base);
        cnt = int'(tc.count);
        for (int i = 0; i < cnt; i++) begin
            mem_write(src + i, $urandom);
        end
        for (int k = 0; k < NUM_PE; k++) begin
            send_cmd(CMD_CFG_PE, ADDR_W'(k), DATA_W'(tc.pe[k]));
        end
        send_cmd(CMD_CFG_LSU, ADDR_W'(0), DATA_W'(tc.src_base));
        send_cmd(CMD_CFG_LSU, ADDR_W'(1), DATA_W'(tc.dst_base));
        send_cmd(CMD_CFG_LSU, ADDR_W'(2), DATA_W'(tc.count));
        run_block();
        for (int i = 0; i < cnt; i++) begin
            d = shadow[src + i];
            for (int k = 0; k < NUM_PE; k++) begin
                d = apply_pe(tc.pe[k], d);
            end
            res.push_back(d);
        end
        for (int i = 0; i < cnt; i++) begin
            shadow[dst + i] = res[i];
        end
        // Destination plus one guard word each side
        for (int a = dst - 1; a <= dst + cnt; a++) begin
            if (a >= 0 && a < SPM_DEPTH) mem_read_check(a);
        end
        if (done_pulses != runs) abort_run("done pulsed while no run was active");
    endtask

    initial begin
        repeat (watch_cycles()) @(posedge clk);
        abort_run("watchdog expired before the test sequence finished");
    end

    initial begin
        cmd       = '0;
        cmd_valid = 1'b0;
        rsp_ready = 1'b0;
        arst_n    = 1'b0;
        runs      = 0;
        void'($urandom(83));
        repeat (8) @(posedge clk);
        #1 arst_n = 1'b1;
        @(negedge clk);
        check_bit("cmd_ready", 1'b1, cmd_ready);
        check_bit("rsp_valid", 1'b0, rsp_valid);
        check_bit("done", 1'b0, done);
        @(posedge clk);
        #1;
        for (int a = 0; a < SPM_DEPTH; a++) begin
            mem_write(a, fill_word(a));
        end
        for (int a = 0; a < SPM_DEPTH; a += 37) begin
            mem_read_check(a);
        end
        for (int i = 0; i < NUM_CASES; i++) begin
            run_case(CASES[i]);
        end
        $display("Done: no errors");
        $finish;
    end

endmodule

//--- verilog.f
+incdir+include
hdl/cgra_pkg.sv
hdl/cgra_spm.sv
hdl/cgra_host_if.sv
hdl/cgra_load_lsu.sv
hdl/cgra_pe.sv
hdl/cgra_store_lsu.sv
hdl/cgra_top.sv
dv/cgra_tb.sv

//--- Bender.yml
package:
  name: cgra_tile

sources:
  - hdl/cgra_pkg.sv
  - hdl/cgra_spm.sv
  - hdl/cgra_host_if.sv
  - hdl/cgra_load_lsu.sv
  - hdl/cgra_pe.sv
  - hdl/cgra_store_lsu.sv
  - hdl/cgra_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - dv/cgra_tb.sv
